/* logic/issue_pkg.sv */
`default_nettype none

package issue_pkg;

    // ##################################################
    // Datapath and register file geometry
    // ##################################################

    localparam int xlen       = 32;
    localparam int preg_width = 6;
    // Register 0 is hard zero
    localparam int num_preg   = 64;

    // ##################################################
    // Port counts
    // ##################################################

    localparam int alu_size       = 2;
    localparam int load_pipeline  = 1;
    localparam int store_pipeline = 1;
    localparam int wb_size        = 3;

    // Two operands per integer slot, one per load and per store slot
    localparam int num_read = alu_size * 2 + load_pipeline + store_pipeline;

    // Integer beats first, then load beats
    localparam int wakeup_size = alu_size + load_pipeline;

endpackage

`default_nettype wire

/* logic/wakeup_ctrl.sv */
`default_nettype none

module wakeup_ctrl #(
    parameter int ALU_SIZE       = issue_pkg::alu_size,
    parameter int LOAD_PIPELINE  = issue_pkg::load_pipeline,
    parameter int STORE_PIPELINE = issue_pkg::store_pipeline,
    parameter int PREG_WIDTH     = issue_pkg::preg_width
) (
    input  logic                                clk,
    input  logic                                rst_n,

    // Integer slots, int_preg carries {src1, src0} per slot
    input  logic [ALU_SIZE-1:0]                 int_en,
    input  logic [ALU_SIZE*PREG_WIDTH-1:0]      int_rd,
    input  logic [ALU_SIZE*2*PREG_WIDTH-1:0]    int_preg,
    output logic [ALU_SIZE-1:0]                 int_ready,

    input  logic                                csr_en,
    input  logic [PREG_WIDTH-1:0]               csr_rd,
    input  logic [PREG_WIDTH-1:0]               csr_preg,
    output logic                                csr_ready,

    input  logic [LOAD_PIPELINE-1:0]            load_en,
    input  logic [LOAD_PIPELINE*PREG_WIDTH-1:0] load_rd,
    input  logic [LOAD_PIPELINE*PREG_WIDTH-1:0] load_preg,

    input  logic [STORE_PIPELINE-1:0]           store_en,
    input  logic [STORE_PIPELINE*PREG_WIDTH-1:0] store_preg,

    output logic [ALU_SIZE+LOAD_PIPELINE-1:0]   wake_en,
    output logic [ALU_SIZE+LOAD_PIPELINE-1:0]   wake_we,
    output logic [(ALU_SIZE+LOAD_PIPELINE)*PREG_WIDTH-1:0] wake_rd,

    output logic [ALU_SIZE*2+LOAD_PIPELINE+STORE_PIPELINE-1:0] rd_en,
    output logic [(ALU_SIZE*2+LOAD_PIPELINE+STORE_PIPELINE)*PREG_WIDTH-1:0] rd_addr
);

    localparam int WAKEUP_SIZE = ALU_SIZE + LOAD_PIPELINE;

    // Slot requests after the CSR merge
    logic [ALU_SIZE-1:0]            slot_en;
    logic [ALU_SIZE*PREG_WIDTH-1:0] slot_rd;
    logic [ALU_SIZE*PREG_WIDTH-1:0] slot_src0;
    logic [ALU_SIZE*PREG_WIDTH-1:0] slot_src1;

    // Registered integer issues
    logic [ALU_SIZE-1:0]            iss_en;
    logic [ALU_SIZE*PREG_WIDTH-1:0] iss_rd;
    logic [ALU_SIZE*PREG_WIDTH-1:0] iss_src0;
    logic [ALU_SIZE*PREG_WIDTH-1:0] iss_src1;

    // ##################################################
    // Slot selection
    // ##################################################

    for (genvar i = 0; i < ALU_SIZE; i++) begin : g_slot
        if (i == 1) begin : g_csr_shared
            // CSR owns slot 1 whenever it fires, the integer request waits
            assign int_ready[i] = ~csr_en;
            assign slot_en[i]   = int_en[i] | csr_en;
            assign slot_rd[i*PREG_WIDTH +: PREG_WIDTH] =
                csr_en ? csr_rd : int_rd[i*PREG_WIDTH +: PREG_WIDTH];
            assign slot_src0[i*PREG_WIDTH +: PREG_WIDTH] =
                csr_en ? csr_preg : int_preg[2*i*PREG_WIDTH +: PREG_WIDTH];
            // Single-source CSR reads the zero register as its second operand
            assign slot_src1[i*PREG_WIDTH +: PREG_WIDTH] =
                csr_en ? '0 : int_preg[(2*i+1)*PREG_WIDTH +: PREG_WIDTH];
        end else begin : g_int_only
            assign int_ready[i] = 1'b1;
            assign slot_en[i]   = int_en[i];
            assign slot_rd[i*PREG_WIDTH +: PREG_WIDTH] = int_rd[i*PREG_WIDTH +: PREG_WIDTH];
            assign slot_src0[i*PREG_WIDTH +: PREG_WIDTH] =
                int_preg[2*i*PREG_WIDTH +: PREG_WIDTH];
            assign slot_src1[i*PREG_WIDTH +: PREG_WIDTH] =
                int_preg[(2*i+1)*PREG_WIDTH +: PREG_WIDTH];
        end
    end

    assign csr_ready = 1'b1;

    // ##################################################
    // Issue register
    // ##################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            iss_en <= '0;
        end else begin
            iss_en <= slot_en;
        end
    end

    always_ff @(posedge clk) begin
        iss_rd   <= slot_rd;
        iss_src0 <= slot_src0;
        iss_src1 <= slot_src1;
    end

    // ##################################################
    // Wakeup bus and read requests
    // ##################################################

    // Loads wake up speculatively in their issue cycle
    assign wake_en = {load_en, iss_en};
    assign wake_rd = {load_rd, iss_rd};

    for (genvar k = 0; k < WAKEUP_SIZE; k++) begin : g_wake_we
        assign wake_we[k] = wake_rd[k*PREG_WIDTH +: PREG_WIDTH] != '0;
    end

    // Order: integer src0, integer src1, load, store
    assign rd_en   = {store_en, load_en, iss_en, iss_en};
    assign rd_addr = {store_preg, load_preg, iss_src1, iss_src0};

endmodule

`default_nettype wire

/* logic/phys_regfile.sv */
`default_nettype none

module phys_regfile #(
    parameter int ALU_SIZE       = issue_pkg::alu_size,
    parameter int LOAD_PIPELINE  = issue_pkg::load_pipeline,
    parameter int STORE_PIPELINE = issue_pkg::store_pipeline,
    parameter int WB_SIZE        = issue_pkg::wb_size,
    parameter int PREG_WIDTH     = issue_pkg::preg_width,
    parameter int NUM_PREG       = issue_pkg::num_preg,
    parameter int XLEN           = issue_pkg::xlen
) (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic [ALU_SIZE*2+LOAD_PIPELINE+STORE_PIPELINE-1:0] rd_en,
    input  logic [(ALU_SIZE*2+LOAD_PIPELINE+STORE_PIPELINE)*PREG_WIDTH-1:0] rd_addr,
    output logic [(ALU_SIZE*2+LOAD_PIPELINE+STORE_PIPELINE)*XLEN-1:0] rd_data,

    input  logic [WB_SIZE-1:0]                  wb_en,
    input  logic [WB_SIZE*PREG_WIDTH-1:0]       wb_rd,
    input  logic [WB_SIZE*XLEN-1:0]             wb_res
);

    localparam int NUM_READ = ALU_SIZE * 2 + LOAD_PIPELINE + STORE_PIPELINE;

    logic [XLEN-1:0]    regs [NUM_PREG];
    logic [WB_SIZE-1:0] wb_we;
    logic [XLEN-1:0]    rd_next [NUM_READ];

    // ##################################################
    // Writeback
    // ##################################################

    // Writes to register 0 are dropped
    for (genvar w = 0; w < WB_SIZE; w++) begin : g_wb_filter
        assign wb_we[w] = wb_en[w] & (wb_rd[w*PREG_WIDTH +: PREG_WIDTH] != '0);
    end

    // Later ports override earlier ones on the same register
    always_ff @(posedge clk) begin
        for (int w = 0; w < WB_SIZE; w++) begin
            if (wb_we[w]) begin
                regs[wb_rd[w*PREG_WIDTH +: PREG_WIDTH]] <= wb_res[w*XLEN +: XLEN];
            end
        end
    end

    // ##################################################
    // Read ports with writeback bypass
    // ##################################################

    always_comb begin
        for (int r = 0; r < NUM_READ; r++) begin
            if (rd_addr[r*PREG_WIDTH +: PREG_WIDTH] == '0) begin
                rd_next[r] = '0;
            end else begin
                rd_next[r] = regs[rd_addr[r*PREG_WIDTH +: PREG_WIDTH]];
            end
            // Highest matching writeback port wins
            for (int w = 0; w < WB_SIZE; w++) begin
                if (wb_we[w] &&
                    wb_rd[w*PREG_WIDTH +: PREG_WIDTH] == rd_addr[r*PREG_WIDTH +: PREG_WIDTH]) begin
                    rd_next[r] = wb_res[w*XLEN +: XLEN];
                end
            end
        end
    end

    // Output holds while the port is idle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else begin
            for (int r = 0; r < NUM_READ; r++) begin
                if (rd_en[r]) begin
                    rd_data[r*XLEN +: XLEN] <= rd_next[r];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/preg_ready_table.sv */
`default_nettype none

module preg_ready_table #(
    parameter int ALU_SIZE      = issue_pkg::alu_size,
    parameter int LOAD_PIPELINE = issue_pkg::load_pipeline,
    parameter int PREG_WIDTH    = issue_pkg::preg_width,
    parameter int NUM_PREG      = issue_pkg::num_preg
) (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic [ALU_SIZE+LOAD_PIPELINE-1:0]   wake_en,
    input  logic [ALU_SIZE+LOAD_PIPELINE-1:0]   wake_we,
    input  logic [(ALU_SIZE+LOAD_PIPELINE)*PREG_WIDTH-1:0] wake_rd,

    input  logic                                alloc_en,
    input  logic [PREG_WIDTH-1:0]               alloc_preg,

    output logic [NUM_PREG-1:0]                 preg_ready
);

    localparam int WAKEUP_SIZE = ALU_SIZE + LOAD_PIPELINE;

    logic [NUM_PREG-1:0] ready_next;

    always_comb begin
        ready_next = preg_ready;
        for (int k = 0; k < WAKEUP_SIZE; k++) begin
            if (wake_en[k] && wake_we[k]) begin
                ready_next[wake_rd[k*PREG_WIDTH +: PREG_WIDTH]] = 1'b1;
            end
        end
        // Allocation overrides a wakeup on the same register
        if (alloc_en) begin
            ready_next[alloc_preg] = 1'b0;
        end
        // Zero register is never pending
        ready_next[0] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            preg_ready <= '1;
        end else begin
            preg_ready <= ready_next;
        end
    end

endmodule

`default_nettype wire

/* logic/issue_read_top.sv */
`default_nettype none

module issue_read_top #(
    parameter int ALU_SIZE       = issue_pkg::alu_size,
    parameter int LOAD_PIPELINE  = issue_pkg::load_pipeline,
    parameter int STORE_PIPELINE = issue_pkg::store_pipeline,
    parameter int WB_SIZE        = issue_pkg::wb_size,
    parameter int PREG_WIDTH     = issue_pkg::preg_width,
    parameter int NUM_PREG       = issue_pkg::num_preg,
    parameter int XLEN           = issue_pkg::xlen
) (
    input  logic                                 clk,
    input  logic                                 rst_n,

    // Integer slots, preg is {src1, src0} and data is {op1, op0} per slot
    input  logic [ALU_SIZE-1:0]                  int_en,
    input  logic [ALU_SIZE*PREG_WIDTH-1:0]       int_rd,
    input  logic [ALU_SIZE*2*PREG_WIDTH-1:0]     int_preg,
    output logic [ALU_SIZE-1:0]                  int_ready,
    output logic [ALU_SIZE*2*XLEN-1:0]           int_data,

    input  logic                                 csr_en,
    input  logic [PREG_WIDTH-1:0]                csr_rd,
    input  logic [PREG_WIDTH-1:0]                csr_preg,
    output logic                                 csr_ready,
    output logic [XLEN-1:0]                      csr_data,

    input  logic [LOAD_PIPELINE-1:0]             load_en,
    input  logic [LOAD_PIPELINE*PREG_WIDTH-1:0]  load_rd,
    input  logic [LOAD_PIPELINE*PREG_WIDTH-1:0]  load_preg,
    output logic [LOAD_PIPELINE-1:0]             load_ready,
    output logic [LOAD_PIPELINE*XLEN-1:0]        load_data,

    input  logic [STORE_PIPELINE-1:0]            store_en,
    input  logic [STORE_PIPELINE*PREG_WIDTH-1:0] store_preg,
    output logic [STORE_PIPELINE-1:0]            store_ready,
    output logic [STORE_PIPELINE*XLEN-1:0]       store_data,

    input  logic [WB_SIZE-1:0]                   wb_en,
    input  logic [WB_SIZE*PREG_WIDTH-1:0]        wb_rd,
    input  logic [WB_SIZE*XLEN-1:0]              wb_res,

    output logic [ALU_SIZE+LOAD_PIPELINE-1:0]    wake_en,
    output logic [ALU_SIZE+LOAD_PIPELINE-1:0]    wake_we,
    output logic [(ALU_SIZE+LOAD_PIPELINE)*PREG_WIDTH-1:0] wake_rd,

    input  logic                                 alloc_en,
    input  logic [PREG_WIDTH-1:0]                alloc_preg,
    output logic [NUM_PREG-1:0]                  preg_ready
);

    localparam int NUM_READ   = ALU_SIZE * 2 + LOAD_PIPELINE + STORE_PIPELINE;
    localparam int LOAD_BASE  = ALU_SIZE * 2;
    localparam int STORE_BASE = ALU_SIZE * 2 + LOAD_PIPELINE;

    logic [NUM_READ-1:0]            rd_en;
    logic [NUM_READ*PREG_WIDTH-1:0] rd_addr;
    logic [NUM_READ*XLEN-1:0]       rd_data;

    wakeup_ctrl #(
        .ALU_SIZE      (ALU_SIZE),
        .LOAD_PIPELINE (LOAD_PIPELINE),
        .STORE_PIPELINE(STORE_PIPELINE),
        .PREG_WIDTH    (PREG_WIDTH)
    ) u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .int_en    (int_en),
        .int_rd    (int_rd),
        .int_preg  (int_preg),
        .int_ready (int_ready),
        .csr_en    (csr_en),
        .csr_rd    (csr_rd),
        .csr_preg  (csr_preg),
        .csr_ready (csr_ready),
        .load_en   (load_en),
        .load_rd   (load_rd),
        .load_preg (load_preg),
        .store_en  (store_en),
        .store_preg(store_preg),
        .wake_en   (wake_en),
        .wake_we   (wake_we),
        .wake_rd   (wake_rd),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr)
    );

    phys_regfile #(
        .ALU_SIZE      (ALU_SIZE),
        .LOAD_PIPELINE (LOAD_PIPELINE),
        .STORE_PIPELINE(STORE_PIPELINE),
        .WB_SIZE       (WB_SIZE),
        .PREG_WIDTH    (PREG_WIDTH),
        .NUM_PREG      (NUM_PREG),
        .XLEN          (XLEN)
    ) u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .rd_en  (rd_en),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .wb_en  (wb_en),
        .wb_rd  (wb_rd),
        .wb_res (wb_res)
    );

    preg_ready_table #(
        .ALU_SIZE     (ALU_SIZE),
        .LOAD_PIPELINE(LOAD_PIPELINE),
        .PREG_WIDTH   (PREG_WIDTH),
        .NUM_PREG     (NUM_PREG)
    ) u_ready (
        .clk       (clk),
        .rst_n     (rst_n),
        .wake_en   (wake_en),
        .wake_we   (wake_we),
        .wake_rd   (wake_rd),
        .alloc_en  (alloc_en),
        .alloc_preg(alloc_preg),
        .preg_ready(preg_ready)
    );

    // ##################################################
    // Operand routing
    // ##################################################

    for (genvar i = 0; i < ALU_SIZE; i++) begin : g_int_data
        assign int_data[2*i*XLEN +: XLEN]     = rd_data[i*XLEN +: XLEN];
        assign int_data[(2*i+1)*XLEN +: XLEN] = rd_data[(ALU_SIZE+i)*XLEN +: XLEN];
    end

    // CSR rides on slot 1's first operand
    assign csr_data = rd_data[XLEN +: XLEN];

    assign load_ready  = '1;
    assign load_data   = rd_data[LOAD_BASE*XLEN +: LOAD_PIPELINE*XLEN];
    assign store_ready = '1;
    assign store_data  = rd_data[STORE_BASE*XLEN +: STORE_PIPELINE*XLEN];

endmodule

`default_nettype wire

/* dv/issue_read_properties.sv */
`default_nettype none

module issue_read_properties #(
    parameter int ALU_SIZE       = issue_pkg::alu_size,
    parameter int LOAD_PIPELINE  = issue_pkg::load_pipeline,
    parameter int STORE_PIPELINE = issue_pkg::store_pipeline
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [ALU_SIZE+LOAD_PIPELINE-1:0] wake_en,
    input  logic [ALU_SIZE-1:0]               int_ready,
    input  logic                              csr_en,
    input  logic [LOAD_PIPELINE-1:0]          load_ready,
    input  logic [STORE_PIPELINE-1:0]         store_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    // Issue registers are cleared by the first reset edge
    wake_quiet_in_reset: assert property (
        @(posedge clk) (!rst_n && $past(!rst_n)) |-> (wake_en == '0)
    ) else $error("wakeup bus active while reset is held");

    // CSR steals integer slot 1
    slot1_ready_vs_csr: assert property (
        @(posedge clk) disable iff (!rst_n) int_ready[1] == ~csr_en
    ) else $error("slot 1 ready does not mirror the CSR enable");

    mem_ready_high: assert property (
        @(posedge clk) disable iff (!rst_n) (&load_ready) && (&store_ready)
    ) else $error("load or store ready dropped");

endmodule

`default_nettype wire

/* dv/issue_read_tb.sv */
`default_nettype none

module issue_read_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import issue_pkg::*;

    localparam int clk_period      = 8;
    localparam int num_tests       = 5;
    localparam int num_rand_writes = 45;
    localparam int num_int_reads   = 16;

    logic                                   clk;
    logic                                   rst_n;
    logic [alu_size-1:0]                    int_en;
    logic [alu_size*preg_width-1:0]         int_rd;
    logic [alu_size*2*preg_width-1:0]       int_preg;
    logic [alu_size-1:0]                    int_ready;
    logic [alu_size*2*xlen-1:0]             int_data;
    logic                                   csr_en;
    logic [preg_width-1:0]                  csr_rd;
    logic [preg_width-1:0]                  csr_preg;
    logic                                   csr_ready;
    logic [xlen-1:0]                        csr_data;
    logic [load_pipeline-1:0]               load_en;
    logic [load_pipeline*preg_width-1:0]    load_rd;
    logic [load_pipeline*preg_width-1:0]    load_preg;
    logic [load_pipeline-1:0]               load_ready;
    logic [load_pipeline*xlen-1:0]          load_data;
    logic [store_pipeline-1:0]              store_en;
    logic [store_pipeline*preg_width-1:0]   store_preg;
    logic [store_pipeline-1:0]              store_ready;
    logic [store_pipeline*xlen-1:0]         store_data;
    logic [wb_size-1:0]                     wb_en;
    logic [wb_size*preg_width-1:0]          wb_rd;
    logic [wb_size*xlen-1:0]                wb_res;
    logic [wakeup_size-1:0]                 wake_en;
    logic [wakeup_size-1:0]                 wake_we;
    logic [wakeup_size*preg_width-1:0]      wake_rd;
    logic                                   alloc_en;
    logic [preg_width-1:0]                  alloc_preg;
    logic [num_preg-1:0]                    preg_ready;

    // Expected register contents
    logic [xlen-1:0] ref_regs [num_preg];
    integer          seed;

    issue_read_top dut (.*);

    bind issue_read_top issue_read_properties u_props (
        .clk        (clk),
        .rst_n      (rst_n),
        .wake_en    (wake_en),
        .int_ready  (int_ready),
        .csr_en     (csr_en),
        .load_ready (load_ready),
        .store_ready(store_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(num_tests * 200 * clk_period);
        $display("timeout: tests did not finish within %0d cycles", num_tests * 200);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    // ##################################################
    // Helpers
    // ##################################################

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("error: time %0t, %s = %h, expected %h", $time, name, actual, expected);
            $display("Verification failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic logic [xlen-1:0] model_read(input logic [preg_width-1:0] preg);
        if (preg == '0) begin
            return '0;
        end
        return ref_regs[preg];
    endfunction

    // Later ports overwrite earlier ones, as in the DUT
    task automatic write_beat(input logic [wb_size-1:0] en,
                              input logic [wb_size*preg_width-1:0] rd,
                              input logic [wb_size*xlen-1:0] res);
        @(posedge clk);
        wb_en  <= en;
        wb_rd  <= rd;
        wb_res <= res;
        for (int w = 0; w < wb_size; w++) begin
            if (en[w] && rd[w*preg_width +: preg_width] != '0) begin
                ref_regs[rd[w*preg_width +: preg_width]] = res[w*xlen +: xlen];
            end
        end
    endtask

    task automatic int_read_check(input logic [alu_size*2*preg_width-1:0] srcs);
        @(posedge clk);
        int_en   <= '1;
        int_preg <= srcs;
        @(posedge clk);
        int_en <= '0;
        @(posedge clk);
        @(negedge clk);
        for (int k = 0; k < alu_size * 2; k++) begin
            check_value($sformatf("int_data[%0d]", k), 64'(int_data[k*xlen +: xlen]),
                        64'(model_read(srcs[k*preg_width +: preg_width])));
        end
    endtask

    task automatic init_inputs();
        rst_n      = 1'b0;
        int_en     = '0;
        int_rd     = '0;
        int_preg   = '0;
        csr_en     = 1'b0;
        csr_rd     = '0;
        csr_preg   = '0;
        load_en    = '0;
        load_rd    = '0;
        load_preg  = '0;
        store_en   = '0;
        store_preg = '0;
        wb_en      = '0;
        wb_rd      = '0;
        wb_res     = '0;
        alloc_en   = 1'b0;
        alloc_preg = '0;
    endtask

    task automatic apply_reset();
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("wake_en", 64'(wake_en), 64'(0));
        check_value("preg_ready", 64'(preg_ready), 64'({num_preg{1'b1}}));
        check_value("int_data[0]", 64'(int_data[0 +: xlen]), 64'(0));
    endtask

    // ##################################################
    // Tests
    // ##################################################

    task automatic test_writeback_int_read();
        logic [xlen-1:0]                  r;
        logic [wb_size-1:0]               en;
        logic [wb_size*preg_width-1:0]    rd;
        logic [wb_size*xlen-1:0]          res;
        logic [alu_size*2*preg_width-1:0] srcs;
        // Fill every register, register 0 included
        for (int base = 0; base < num_preg; base += wb_size) begin
            for (int w = 0; w < wb_size; w++) begin
                r = xlen'($random(seed));
                en[w] = (base + w) < num_preg;
                rd[w*preg_width +: preg_width] = preg_width'(base + w);
                res[w*xlen +: xlen] = r;
            end
            write_beat(en, rd, res);
        end
        for (int n = 0; n < num_rand_writes / wb_size; n++) begin
            for (int w = 0; w < wb_size; w++) begin
                r = xlen'($random(seed));
                en[w] = r[xlen-1];
                rd[w*preg_width +: preg_width] = r[preg_width-1:0];
                r = xlen'($random(seed));
                res[w*xlen +: xlen] = r;
            end
            // Collide the last port with port 0 on every other beat
            if (n % 2 == 0) begin
                rd[(wb_size-1)*preg_width +: preg_width] = rd[0 +: preg_width];
            end
            write_beat(en, rd, res);
        end
        @(posedge clk);
        wb_en <= '0;
        for (int n = 0; n < num_int_reads; n++) begin
            for (int k = 0; k < alu_size * 2; k++) begin
                r = xlen'($random(seed));
                srcs[k*preg_width +: preg_width] = r[preg_width-1:0];
            end
            if (n == 0) begin
                srcs[0 +: preg_width] = '0;
            end
            int_read_check(srcs);
        end
    endtask

    task automatic test_wakeup_timing();
        @(posedge clk);
        int_en <= '1;
        int_rd[0 +: preg_width]          <= preg_width'(5);
        int_rd[preg_width +: preg_width] <= '0;
        @(negedge clk);
        check_value("wake_en[0]", 64'(wake_en[0]), 64'(0));
        @(posedge clk);
        int_en <= '0;
        @(negedge clk);
        check_value("wake_en[1:0]", 64'(wake_en[1:0]), 64'(3));
        check_value("wake_rd[0]", 64'(wake_rd[0 +: preg_width]), 64'(5));
        check_value("wake_rd[1]", 64'(wake_rd[preg_width +: preg_width]), 64'(0));
        check_value("wake_we[1:0]", 64'(wake_we[1:0]), 64'(1));
        @(posedge clk);
        @(negedge clk);
        check_value("wake_en[1:0]", 64'(wake_en[1:0]), 64'(0));
        // Load beat is combinational
        @(posedge clk);
        load_en <= '1;
        load_rd <= preg_width'(9);
        @(negedge clk);
        check_value("wake_en[load]", 64'(wake_en[alu_size]), 64'(1));
        check_value("wake_rd[load]", 64'(wake_rd[alu_size*preg_width +: preg_width]), 64'(9));
        check_value("wake_we[load]", 64'(wake_we[alu_size]), 64'(1));
        @(posedge clk);
        load_rd <= '0;
        @(negedge clk);
        check_value("wake_we[load]", 64'(wake_we[alu_size]), 64'(0));
        @(posedge clk);
        load_en <= '0;
        @(negedge clk);
        check_value("wake_en[load]", 64'(wake_en[alu_size]), 64'(0));
    endtask

    task automatic test_csr_takeover();
        logic [preg_width-1:0] src;
        src = preg_width'(33);
        @(posedge clk);
        int_en <= alu_size'(2);
        int_rd[preg_width +: preg_width] <= preg_width'(7);
        csr_en   <= 1'b1;
        csr_rd   <= preg_width'(12);
        csr_preg <= src;
        @(negedge clk);
        check_value("int_ready[1]", 64'(int_ready[1]), 64'(0));
        check_value("int_ready[0]", 64'(int_ready[0]), 64'(1));
        check_value("csr_ready", 64'(csr_ready), 64'(1));
        @(posedge clk);
        int_en <= '0;
        csr_en <= 1'b0;
        @(negedge clk);
        check_value("int_ready[1]", 64'(int_ready[1]), 64'(1));
        check_value("wake_en[1]", 64'(wake_en[1]), 64'(1));
        check_value("wake_rd[1]", 64'(wake_rd[preg_width +: preg_width]), 64'(12));
        check_value("wake_we[1]", 64'(wake_we[1]), 64'(1));
        @(posedge clk);
        @(negedge clk);
        check_value("csr_data", 64'(csr_data), 64'(model_read(src)));
    endtask

    task automatic test_load_store_read();
        logic [preg_width-1:0]         a;
        logic [preg_width-1:0]         b;
        logic [wb_size-1:0]            en;
        logic [wb_size*preg_width-1:0] rd;
        logic [wb_size*xlen-1:0]       res;
        a = preg_width'(17);
        b = preg_width'(40);
        @(posedge clk);
        load_en    <= '1;
        load_preg  <= a;
        store_en   <= '1;
        store_preg <= b;
        @(negedge clk);
        check_value("load_ready", 64'(load_ready), 64'({load_pipeline{1'b1}}));
        check_value("store_ready", 64'(store_ready), 64'({store_pipeline{1'b1}}));
        @(posedge clk);
        load_en    <= '0;
        load_preg  <= '0;
        store_en   <= '0;
        store_preg <= '0;
        @(negedge clk);
        check_value("load_data", 64'(load_data), 64'(model_read(a)));
        check_value("store_data", 64'(store_data), 64'(model_read(b)));
        @(posedge clk);
        @(negedge clk);
        check_value("load_data", 64'(load_data), 64'(model_read(a)));
        // Two ports write the read register in the issue cycle
        en  = '0;
        rd  = '0;
        res = '0;
        en[0] = 1'b1;
        en[wb_size-1] = 1'b1;
        rd[0 +: preg_width] = b;
        rd[(wb_size-1)*preg_width +: preg_width] = b;
        res[0 +: xlen] = xlen'($random(seed));
        res[(wb_size-1)*xlen +: xlen] = xlen'($random(seed));
        write_beat(en, rd, res);
        load_en    <= '1;
        load_preg  <= b;
        store_en   <= '1;
        store_preg <= b;
        @(posedge clk);
        wb_en    <= '0;
        load_en  <= '0;
        store_en <= '0;
        @(negedge clk);
        check_value("load_data", 64'(load_data), 64'(model_read(b)));
        check_value("store_data", 64'(store_data), 64'(model_read(b)));
    endtask

    task automatic test_ready_table();
        logic [preg_width-1:0] p;
        logic [preg_width-1:0] q;
        p = preg_width'(20);
        q = preg_width'(21);
        @(posedge clk);
        alloc_en   <= 1'b1;
        alloc_preg <= p;
        @(posedge clk);
        alloc_en <= 1'b0;
        load_en  <= '1;
        load_rd  <= p;
        @(negedge clk);
        check_value("preg_ready[p]", 64'(preg_ready[p]), 64'(0));
        @(posedge clk);
        load_en <= '0;
        @(negedge clk);
        check_value("preg_ready[p]", 64'(preg_ready[p]), 64'(1));
        // Allocation and wakeup on the same register in one cycle
        @(posedge clk);
        alloc_en   <= 1'b1;
        alloc_preg <= q;
        @(posedge clk);
        load_en <= '1;
        load_rd <= q;
        @(posedge clk);
        alloc_en <= 1'b0;
        load_en  <= '0;
        @(negedge clk);
        check_value("preg_ready[q]", 64'(preg_ready[q]), 64'(0));
        @(posedge clk);
        alloc_en   <= 1'b1;
        alloc_preg <= '0;
        @(posedge clk);
        alloc_en <= 1'b0;
        @(negedge clk);
        check_value("preg_ready[0]", 64'(preg_ready[0]), 64'(1));
    endtask

    initial begin
        seed = 57;
        init_inputs();
        apply_reset();
        test_writeback_int_read();
        test_wakeup_timing();
        test_csr_takeover();
        test_load_store_read();
        test_ready_table();
        @(posedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
logic/issue_pkg.sv
logic/wakeup_ctrl.sv
logic/phys_regfile.sv
logic/preg_ready_table.sv
logic/issue_read_top.sv
dv/issue_read_properties.sv
dv/issue_read_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile the issue-read testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module issue_read_tb \
    -f filelist.f \
    -o issue_read_sim \
    && ./obj_dir/issue_read_sim > sim.log 2>&1 \
    || echo "build or simulation ended with an error" >> sim.log

cat sim.log

# A fail line or a missing pass line counts as failure
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
